// ==== verilog/rtab_cfg_pkg.sv ====
/*
 * Default sizes of the replay table.
 * The top level takes these as parameter defaults and passes them down.
 * The payload tag width is fixed for every configuration.
 */
`default_nettype none

package rtab_cfg_pkg;

    // Number of table entries
    localparam int NUM_ENTRIES = 8;

    // Width of a cache-line index
    localparam int NLINE_WIDTH = 12;

    // Opaque request tag carried with each entry
    localparam int PAYLOAD_WIDTH = 8;

endpackage

`default_nettype wire

// ==== verilog/rtab_types_pkg.sv ====
/*
 * Types shared by the replay table modules and its testbench.
 * Holds the pop walk states, the request opcodes and the names of the
 * dependency bits. Entry records are built per module from these.
 */
`default_nettype none

package rtab_types_pkg;

    // States of the list walk during pop try
    typedef enum logic [1:0] {
        POP_HEAD      = 2'd0,
        POP_NEXT      = 2'd1,
        POP_NEXT_WAIT = 2'd2
    } rtab_pop_state_e;

    // Request opcode, stored and returned untouched
    typedef enum logic [1:0] {
        LOAD     = 2'd0,
        STORE    = 2'd1,
        PREFETCH = 2'd2
    } rtab_op_e;

    // Bit positions inside rtab_deps_t
    typedef enum int {
        DEP_MSHR_HIT   = 0,
        DEP_MISS_READY = 1
    } rtab_dep_e;

    // One bit per pending dependency, indexed by rtab_dep_e
    typedef logic [1:0] rtab_deps_t;

endpackage

`default_nettype wire

// ==== verilog/rtab_pop_if.sv ====
/*
 * Link between the pop FSM and the entry store.
 * The FSM selects an entry and reports when the consumer takes it,
 * the store answers with the tail flag and next pointer of that entry.
 */
`timescale 1ns/10ps
`default_nettype none

interface rtab_pop_if #(
    parameter int NumEntries = 8
);

    logic [NumEntries-1:0] pop_sel;
    logic                  pop_try_fire;
    logic                  selected_is_tail;
    logic [NumEntries-1:0] selected_next;

    modport fsm (output pop_sel, pop_try_fire, input selected_is_tail, selected_next);

    modport store (input pop_sel, pop_try_fire, output selected_is_tail, selected_next);

endinterface

`default_nettype wire

// ==== verilog/rtab_entry_store.sv ====
/*
 * Entry storage of the replay table.
 * Keeps the payload, the valid/head/tail flags and the one-hot next
 * pointers that chain requests to the same line. Allocates the lowest
 * free slot and muxes out the entry selected by the pop FSM.
 */
`timescale 1ns/10ps
`default_nettype none

module rtab_entry_store #(
    parameter int  NumEntries = 8,
    parameter int  NlineWidth = 12,
    localparam int PtrWidth   = (NumEntries > 1) ? $clog2(NumEntries) : 1
) (
    input  logic                                     clk_i,
    input  logic                                     rst_ni,
    input  logic [NlineWidth-1:0]                    check_nline_i,
    output logic                                     check_hit_o,
    input  logic                                     alloc_i,
    input  logic                                     alloc_link_i,
    input  logic [NlineWidth-1:0]                    alloc_nline_i,
    input  rtab_types_pkg::rtab_op_e                 alloc_op_i,
    input  logic [rtab_cfg_pkg::PAYLOAD_WIDTH-1:0]   alloc_tag_i,
    input  logic                                     pop_commit_i,
    input  logic [PtrWidth-1:0]                      pop_commit_ptr_i,
    input  logic                                     pop_rback_i,
    input  logic [PtrWidth-1:0]                      pop_rback_ptr_i,
    output logic [NumEntries-1:0]                    valid_o,
    output logic [NumEntries-1:0]                    head_o,
    output logic [NumEntries-1:0]                    write_set_o,
    output logic [NumEntries-1:0][NlineWidth-1:0]    entry_nline_o,
    output logic [NlineWidth-1:0]                    pop_nline_o,
    output rtab_types_pkg::rtab_op_e                 pop_op_o,
    output logic [rtab_cfg_pkg::PAYLOAD_WIDTH-1:0]   pop_tag_o,
    output logic [PtrWidth-1:0]                      pop_ptr_o,
    output logic                                     empty_o,
    output logic                                     full_o,
    rtab_pop_if.store                                pop_if
);

    typedef struct packed {
        logic [NlineWidth-1:0]                  nline;
        rtab_types_pkg::rtab_op_e               op;
        logic [rtab_cfg_pkg::PAYLOAD_WIDTH-1:0] tag;
    } entry_t;

    entry_t [NumEntries-1:0]                 entry_q;
    logic   [NumEntries-1:0][NumEntries-1:0] next_q;
    logic   [NumEntries-1:0]                 valid_q, head_q, tail_q;
    logic   [NumEntries-1:0]                 free_oh, match, match_tail;
    logic   [NumEntries-1:0]                 commit_oh, rback_oh, alloc_oh, pop_oh;
    logic   [NumEntries-1:0]                 sel_next;
    logic                                    sel_tail, alloc, new_head;
    logic                                    link_to_commit, link_into_sel;
    entry_t                                  pop_entry;

    for (genvar i = 0; i < NumEntries; i++) begin : g_entry
        assign match[i]         = valid_q[i] && (entry_q[i].nline == check_nline_i);
        assign commit_oh[i]     = pop_commit_i && (pop_commit_ptr_i == PtrWidth'(i));
        assign rback_oh[i]      = pop_rback_i && (pop_rback_ptr_i == PtrWidth'(i));
        assign entry_nline_o[i] = entry_q[i].nline;
    end

    // Lowest clear bit of the valid vector
    assign free_oh    = ~valid_q & (valid_q + NumEntries'(1));
    assign alloc      = alloc_i | alloc_link_i;
    assign alloc_oh   = free_oh & {NumEntries{alloc}};
    assign match_tail = match & tail_q;
    assign pop_oh     = pop_if.pop_sel & {NumEntries{pop_if.pop_try_fire}};

    // Linking behind a tail that leaves this cycle makes the new entry a head
    assign link_to_commit = |(match_tail & commit_oh);
    assign new_head       = alloc_i | (alloc_link_i & link_to_commit);

    // Linking behind the selected entry turns it into a non-tail right away
    assign link_into_sel  = alloc_link_i & (|(match_tail & pop_if.pop_sel));

    assign check_hit_o = |match;
    assign empty_o     = ~(|valid_q);
    assign full_o      = &valid_q;
    assign valid_o     = valid_q;
    assign head_o      = head_q;
    assign write_set_o = alloc_oh | rback_oh;

    always_comb begin
        pop_entry = '0;
        pop_ptr_o = '0;
        sel_next  = '0;
        sel_tail  = 1'b0;
        for (int i = 0; i < NumEntries; i++) begin
            if (pop_if.pop_sel[i]) begin
                pop_entry = entry_q[i];
                pop_ptr_o = PtrWidth'(i);
                sel_next  = next_q[i];
                sel_tail  = tail_q[i];
            end
        end
    end

    assign pop_nline_o = pop_entry.nline;
    assign pop_op_o    = pop_entry.op;
    assign pop_tag_o   = pop_entry.tag;

    assign pop_if.selected_is_tail = sel_tail & ~link_into_sel;
    assign pop_if.selected_next    = link_into_sel ? free_oh : sel_next;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
        end else begin
            valid_q <= (valid_q | alloc_oh) & ~commit_oh;
            // Popped heads are hidden until commit or rollback
            head_q  <= (head_q & ~pop_oh) | (free_oh & {NumEntries{new_head}}) | rback_oh;
            tail_q  <= (tail_q & ~(match_tail & {NumEntries{alloc_link_i}})) | alloc_oh;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < NumEntries; i++) begin
            if (write_set_o[i]) begin
                entry_q[i] <= '{nline: alloc_nline_i, op: alloc_op_i, tag: alloc_tag_i};
            end
            if (alloc_link_i && match_tail[i]) begin
                next_q[i] <= free_oh;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rtab_dep_tracker.sv ====
/*
 * Pending dependency flags of every table entry.
 * Flags are loaded when a slot is written by an allocation or a rollback
 * and cleared one edge after their refill or miss-ready event.
 */
`timescale 1ns/10ps
`default_nettype none

module rtab_dep_tracker #(
    parameter int NumEntries = 8,
    parameter int NlineWidth = 12
) (
    input  logic                                  clk_i,
    input  logic                                  rst_ni,
    input  logic [NumEntries-1:0]                 alloc_set_i,
    input  rtab_types_pkg::rtab_deps_t            alloc_deps_i,
    input  logic [NumEntries-1:0][NlineWidth-1:0] entry_nline_i,
    input  logic [NumEntries-1:0]                 valid_i,
    input  logic                                  refill_i,
    input  logic [NlineWidth-1:0]                 refill_nline_i,
    input  logic                                  miss_ready_i,
    output logic [NumEntries-1:0]                 nodeps_o
);

    rtab_types_pkg::rtab_deps_t [NumEntries-1:0] deps_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            deps_q <= '0;
        end else begin
            for (int i = 0; i < NumEntries; i++) begin
                if (alloc_set_i[i]) begin
                    deps_q[i] <= alloc_deps_i;
                end else begin
                    // Refill of the same line releases the MSHR hit
                    if (refill_i && (entry_nline_i[i] == refill_nline_i)) begin
                        deps_q[i][rtab_types_pkg::DEP_MSHR_HIT] <= 1'b0;
                    end
                    if (miss_ready_i) begin
                        deps_q[i][rtab_types_pkg::DEP_MISS_READY] <= 1'b0;
                    end
                end
            end
        end
    end

    for (genvar i = 0; i < NumEntries; i++) begin : g_nodeps
        assign nodeps_o[i] = valid_i[i] && (deps_q[i] == '0);
    end

endmodule

`default_nettype wire

// ==== verilog/rtab_rr_arbiter.sv ====
/*
 * Round-robin arbiter for the ready list heads.
 * Grants the first requester at or after the priority pointer, the
 * pointer steps past the winner when the grant is consumed.
 */
`timescale 1ns/10ps
`default_nettype none

module rtab_rr_arbiter #(
    parameter int  NumEntries = 8,
    localparam int PtrWidth   = (NumEntries > 1) ? $clog2(NumEntries) : 1
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic [NumEntries-1:0] req_i,
    input  logic                  advance_i,
    output logic [NumEntries-1:0] gnt_o
);

    logic [PtrWidth-1:0] ptr_q;
    logic [PtrWidth-1:0] gnt_idx;

    always_comb begin
        int   idx;
        logic found;
        gnt_o   = '0;
        gnt_idx = ptr_q;
        found   = 1'b0;
        for (int i = 0; i < NumEntries; i++) begin
            idx = int'(ptr_q) + i;
            if (idx >= NumEntries) begin
                idx = idx - NumEntries;
            end
            if (!found && req_i[idx]) begin
                found      = 1'b1;
                gnt_o[idx] = 1'b1;
                gnt_idx    = PtrWidth'(idx);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ptr_q <= '0;
        end else if (advance_i) begin
            ptr_q <= (gnt_idx == PtrWidth'(NumEntries - 1)) ? '0 : gnt_idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rtab_pop_fsm.sv ====
/*
 * Pop walk of the replay table.
 * Offers the granted list head, then follows the next pointers until the
 * tail. Holds the offered entry under back-pressure and falls back to
 * head selection when the consumer rolls an entry back.
 */
`timescale 1ns/10ps
`default_nettype none

module rtab_pop_fsm #(
    parameter int NumEntries = 8
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic [NumEntries-1:0] ready_i,
    input  logic [NumEntries-1:0] head_gnt_i,
    input  logic                  pop_try_i,
    input  logic                  pop_rback_i,
    output logic                  pop_try_valid_o,
    output logic                  advance_o,
    rtab_pop_if.fsm               pop_if
);

    rtab_types_pkg::rtab_pop_state_e state_q, state_d;
    logic [NumEntries-1:0]           next_q, next_d;
    logic                            in_head;
    logic                            fire;

    assign in_head = (state_q == rtab_types_pkg::POP_HEAD);

    // Inside a list the next entry is always available
    assign pop_try_valid_o = in_head ? |ready_i : 1'b1;
    assign pop_if.pop_sel  = in_head ? head_gnt_i : next_q;

    assign fire                = pop_try_i & pop_try_valid_o & ~pop_rback_i;
    assign pop_if.pop_try_fire = fire;
    assign advance_o           = fire & in_head;

    always_comb begin
        state_d = state_q;
        next_d  = next_q;
        case (state_q)
            rtab_types_pkg::POP_HEAD: begin
                if (fire && !pop_if.selected_is_tail) begin
                    state_d = rtab_types_pkg::POP_NEXT;
                    next_d  = pop_if.selected_next;
                end
            end
            rtab_types_pkg::POP_NEXT, rtab_types_pkg::POP_NEXT_WAIT: begin
                if (pop_rback_i) begin
                    state_d = rtab_types_pkg::POP_HEAD;
                end else if (fire) begin
                    if (pop_if.selected_is_tail) begin
                        state_d = rtab_types_pkg::POP_HEAD;
                    end else begin
                        state_d = rtab_types_pkg::POP_NEXT;
                        next_d  = pop_if.selected_next;
                    end
                end else begin
                    state_d = rtab_types_pkg::POP_NEXT_WAIT;
                end
            end
            default: begin
                state_d = rtab_types_pkg::POP_HEAD;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= rtab_types_pkg::POP_HEAD;
            next_q  <= '0;
        end else begin
            state_q <= state_d;
            next_q  <= next_d;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/replay_table.sv ====
/*
 * Replay table for a non-blocking cache.
 * Stores requests that could not be served, chains those to the same
 * line and replays them through a try, commit and rollback handshake.
 */
`timescale 1ns/10ps
`default_nettype none

module replay_table #(
    parameter int  NumEntries = rtab_cfg_pkg::NUM_ENTRIES,
    parameter int  NlineWidth = rtab_cfg_pkg::NLINE_WIDTH,
    localparam int PtrWidth   = (NumEntries > 1) ? $clog2(NumEntries) : 1
) (
    input  logic                                   clk_i,
    input  logic                                   rst_ni,
    input  logic [NlineWidth-1:0]                  check_nline_i,
    output logic                                   check_hit_o,
    input  logic                                   alloc_i,
    input  logic                                   alloc_link_i,
    input  logic [NlineWidth-1:0]                  alloc_nline_i,
    input  rtab_types_pkg::rtab_op_e               alloc_op_i,
    input  logic [rtab_cfg_pkg::PAYLOAD_WIDTH-1:0] alloc_tag_i,
    input  rtab_types_pkg::rtab_deps_t             alloc_deps_i,
    output logic                                   pop_try_valid_o,
    input  logic                                   pop_try_i,
    output logic [NlineWidth-1:0]                  pop_nline_o,
    output rtab_types_pkg::rtab_op_e               pop_op_o,
    output logic [rtab_cfg_pkg::PAYLOAD_WIDTH-1:0] pop_tag_o,
    output logic [PtrWidth-1:0]                    pop_ptr_o,
    input  logic                                   pop_commit_i,
    input  logic [PtrWidth-1:0]                    pop_commit_ptr_i,
    input  logic                                   pop_rback_i,
    input  logic [PtrWidth-1:0]                    pop_rback_ptr_i,
    input  logic                                   refill_i,
    input  logic [NlineWidth-1:0]                  refill_nline_i,
    input  logic                                   miss_ready_i,
    output logic                                   empty_o,
    output logic                                   full_o
);

    logic [NumEntries-1:0]                 valid, head, nodeps, ready;
    logic [NumEntries-1:0]                 write_set, head_gnt;
    logic [NumEntries-1:0][NlineWidth-1:0] entry_nline;
    logic                                  advance;

    rtab_pop_if #(.NumEntries(NumEntries)) pop_if ();

    // A list head may replay once nothing blocks it
    assign ready = valid & head & nodeps;

    rtab_entry_store #(
        .NumEntries(NumEntries),
        .NlineWidth(NlineWidth)
    ) i_store (
        .clk_i, .rst_ni, .check_nline_i, .check_hit_o,
        .alloc_i, .alloc_link_i, .alloc_nline_i, .alloc_op_i, .alloc_tag_i,
        .pop_commit_i, .pop_commit_ptr_i, .pop_rback_i, .pop_rback_ptr_i,
        .valid_o       (valid),
        .head_o        (head),
        .write_set_o   (write_set),
        .entry_nline_o (entry_nline),
        .pop_nline_o, .pop_op_o, .pop_tag_o, .pop_ptr_o, .empty_o, .full_o,
        .pop_if        (pop_if.store)
    );

    rtab_dep_tracker #(
        .NumEntries(NumEntries),
        .NlineWidth(NlineWidth)
    ) i_deps (
        .clk_i, .rst_ni,
        .alloc_set_i   (write_set),
        .alloc_deps_i,
        .entry_nline_i (entry_nline),
        .valid_i       (valid),
        .refill_i, .refill_nline_i, .miss_ready_i,
        .nodeps_o      (nodeps)
    );

    rtab_rr_arbiter #(.NumEntries(NumEntries)) i_arb (
        .clk_i, .rst_ni,
        .req_i     (ready),
        .advance_i (advance),
        .gnt_o     (head_gnt)
    );

    rtab_pop_fsm #(.NumEntries(NumEntries)) i_fsm (
        .clk_i, .rst_ni,
        .ready_i    (ready),
        .head_gnt_i (head_gnt),
        .pop_try_i, .pop_rback_i, .pop_try_valid_o,
        .advance_o  (advance),
        .pop_if     (pop_if.fsm)
    );

endmodule

`default_nettype wire

// ==== verification/replay_table_props.sv ====
/*
 * Handshake assertions for the replay table ports.
 * Bound to every replay_table instance.
 */
`timescale 1ns/10ps
`default_nettype none

module replay_table_props #(
    parameter int  NumEntries = 8,
    parameter int  NlineWidth = 12,
    localparam int PtrWidth   = (NumEntries > 1) ? $clog2(NumEntries) : 1
) (
    input wire logic                  clk_i,
    input wire logic                  rst_ni,
    input wire logic                  pop_try_i,
    input wire logic                  pop_try_valid_o,
    input wire logic [PtrWidth-1:0]   pop_ptr_o,
    input wire logic                  pop_commit_i,
    input wire logic [PtrWidth-1:0]   pop_commit_ptr_i,
    input wire logic                  pop_rback_i,
    input wire logic [PtrWidth-1:0]   pop_rback_ptr_i,
    input wire logic                  alloc_i,
    input wire logic                  alloc_link_i,
    input wire logic                  full_o,
    input wire logic                  check_hit_o,
    input wire logic [NlineWidth-1:0] check_nline_i,
    input wire logic [NlineWidth-1:0] alloc_nline_i
);

    assert property (@(posedge clk_i) disable iff (!rst_ni) pop_try_i |-> pop_try_valid_o)
        else $error("pop try without a valid offer");

    // The taken pop resolves in the very next cycle
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_try_i |=> (pop_commit_i ^ pop_rback_i))
        else $error("taken pop not resolved by exactly one of commit and rollback");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        $past(pop_try_i) && pop_commit_i |-> pop_commit_ptr_i == $past(pop_ptr_o))
        else $error("commit pointer differs from popped pointer");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        $past(pop_try_i) && pop_rback_i |-> pop_rback_ptr_i == $past(pop_ptr_o))
        else $error("rollback pointer differs from popped pointer");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_rback_i |-> !pop_try_i && !alloc_i && !alloc_link_i)
        else $error("pop try or allocation during rollback");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (alloc_i || alloc_link_i) |-> !full_o && !(alloc_i && alloc_link_i))
        else $error("allocation while full or with both alloc kinds");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        alloc_link_i |-> check_hit_o && (check_nline_i == alloc_nline_i))
        else $error("link allocation without a matching check hit");

endmodule

bind replay_table replay_table_props #(
    .NumEntries(NumEntries),
    .NlineWidth(NlineWidth)
) i_props (.*);

`default_nettype wire

// ==== verification/replay_table_tb.sv ====
/*
 * Testbench for the replay table.
 * Drives random allocations, pops, commits, rollbacks and dependency
 * events, and checks every cycle against a slot level model.
 */
`timescale 1ns/10ps
`default_nettype none

module replay_table_tb;

    localparam int N  = rtab_cfg_pkg::NUM_ENTRIES;
    localparam int W  = rtab_cfg_pkg::NLINE_WIDTH;
    localparam int PW = $clog2(N);

    logic clk_i, rst_ni, check_hit_o, alloc_i, alloc_link_i, pop_try_valid_o, pop_try_i;
    logic pop_commit_i, pop_rback_i, refill_i, miss_ready_i, empty_o, full_o;
    logic [W-1:0]  check_nline_i, alloc_nline_i, pop_nline_o, refill_nline_i;
    logic [7:0]    alloc_tag_i, pop_tag_o;
    logic [PW-1:0] pop_ptr_o, pop_commit_ptr_i, pop_rback_ptr_i;
    logic [1:0]    alloc_deps_i;
    rtab_types_pkg::rtab_op_e alloc_op_i, pop_op_o;

    // Slot level model of the table
    logic [N-1:0]  m_valid, m_head;
    logic [W-1:0]  m_line [N];
    logic [1:0]    m_op   [N];
    logic [7:0]    m_tag  [N];
    logic [1:0]    m_deps [N];
    int            m_seq  [N];
    int            seed, seq_cnt, count, cyc;
    logic          outst, walk;
    logic [PW-1:0] out_ptr;
    logic [W-1:0]  walk_line;

    replay_table i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string msg);
        if (actual !== expected) begin
            $display("Mismatch at %0d ns: %s (got %0h, expected %0h)",
                     $time, msg, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "stopping on first error");
        end
    endtask

    function automatic logic line_hit(input logic [W-1:0] line);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < N; i++) begin
            if (m_valid[i] && m_line[i] == line) hit = 1'b1;
        end
        return hit;
    endfunction

    // Youngest valid slot of a line or -1 if none
    function automatic int tail_of(input logic [W-1:0] line);
        int t;
        t = -1;
        for (int i = 0; i < N; i++) begin
            if (m_valid[i] && m_line[i] == line && (t < 0 || m_seq[i] > m_seq[t])) t = i;
        end
        return t;
    endfunction

    function automatic int older_in_line(input int p);
        int n;
        n = 0;
        for (int i = 0; i < N; i++) begin
            if (i != p && m_valid[i] && m_line[i] == m_line[p] && m_seq[i] < m_seq[p]) n++;
        end
        return n;
    endfunction

    function automatic logic exp_try_valid();
        logic v;
        v = walk;
        for (int i = 0; i < N; i++) begin
            if (m_valid[i] && m_head[i] && m_deps[i] == 2'b00) v = 1'b1;
        end
        return v;
    endfunction

    // Alloc mode is 0 for none, 1 for random and 2 for every cycle
    task automatic drive_cycle(input int alloc_mode, input logic allow_pop, input logic drain);
        logic [31:0] r;
        logic [W-1:0] line;
        logic do_alloc, link, do_rback;
        @(posedge clk_i);
        r = $random(seed);
        line = W'(12'h100) + W'($random(seed) & 3);
        do_rback = outst && !drain && (r[1:0] == 2'b00);
        do_alloc = !do_rback && count < N && (alloc_mode == 2 || (alloc_mode == 1 && r[3]));
        link = do_alloc && line_hit(line);
        pop_commit_i     <= outst && !do_rback;
        pop_commit_ptr_i <= out_ptr;
        pop_rback_i      <= do_rback;
        pop_rback_ptr_i  <= out_ptr;
        pop_try_i        <= !outst && allow_pop && exp_try_valid() && (drain || r[2]);
        alloc_i          <= do_alloc && !link;
        alloc_link_i     <= link;
        check_nline_i    <= line;
        alloc_nline_i    <= do_rback ? m_line[out_ptr] : line;
        alloc_op_i       <= rtab_types_pkg::rtab_op_e'(2'((r[31:16]) % 3));
        alloc_tag_i      <= r[15:8];
        alloc_deps_i     <= link ? 2'b00 : r[10:9];
        refill_i         <= drain || (r[5:4] == 2'b00);
        refill_nline_i   <= drain ? W'(12'h100) + W'(cyc & 3) : W'(12'h100) + W'(r[12:11]);
        miss_ready_i     <= drain || (r[8:6] == 3'b000);
        cyc++;
    endtask

    task automatic check_and_update();
        int p, free, tail, cp;
        @(negedge clk_i);
        check_eq(32'(check_hit_o), 32'(line_hit(check_nline_i)), "check hit");
        check_eq(32'(empty_o), 32'(count == 0), "empty flag");
        check_eq(32'(full_o), 32'(count == N), "full flag");
        check_eq(32'(pop_try_valid_o), 32'(exp_try_valid()), "pop try valid");
        p = int'(pop_ptr_o);
        if (pop_try_i) begin
            check_eq(32'(m_valid[p]), 1, "popped entry is valid");
            check_eq(32'(walk ? (m_line[p] == walk_line) : m_head[p]), 1, "popped entry is head");
            check_eq(32'(m_deps[p]), 0, "popped entry has no pending dependency");
            check_eq(older_in_line(p), 0, "list popped in allocation order");
            check_eq(32'(pop_nline_o), 32'(m_line[p]), "popped line");
            check_eq(32'(pop_op_o), 32'(m_op[p]), "popped opcode");
            check_eq(32'(pop_tag_o), 32'(m_tag[p]), "popped tag");
        end
        free = -1;
        for (int i = N - 1; i >= 0; i--) begin
            if (!m_valid[i]) free = i;
        end
        tail = tail_of(alloc_nline_i);
        cp = int'(pop_commit_ptr_i);
        for (int i = 0; i < N; i++) begin
            if (refill_i && m_line[i] == refill_nline_i) m_deps[i][0] = 1'b0;
            if (miss_ready_i) m_deps[i][1] = 1'b0;
        end
        if (pop_commit_i) begin
            m_valid[cp] = 1'b0;
            count--;
            outst = 1'b0;
        end
        if (pop_rback_i) begin
            m_head[out_ptr] = 1'b1;
            m_op[out_ptr]   = alloc_op_i;
            m_tag[out_ptr]  = alloc_tag_i;
            m_deps[out_ptr] = alloc_deps_i;
            outst = 1'b0;
            walk  = 1'b0;
        end
        if (alloc_i || alloc_link_i) begin
            m_valid[free] = 1'b1;
            m_head[free]  = alloc_i || (pop_commit_i && tail == cp);
            m_line[free]  = alloc_nline_i;
            m_op[free]    = alloc_op_i;
            m_tag[free]   = alloc_tag_i;
            m_deps[free]  = alloc_deps_i;
            m_seq[free]   = seq_cnt;
            seq_cnt++;
            count++;
        end
        if (pop_try_i) begin
            m_head[p] = 1'b0;
            outst     = 1'b1;
            out_ptr   = pop_ptr_o;
            walk      = tail_of(m_line[p]) != p;
            walk_line = m_line[p];
        end
    endtask

    initial begin
        int guard;
        seed = 29;
        {alloc_i, alloc_link_i, pop_try_i, pop_commit_i, pop_rback_i} = '0;
        {refill_i, miss_ready_i, alloc_tag_i, alloc_deps_i} = '0;
        {check_nline_i, alloc_nline_i, refill_nline_i} = '0;
        {pop_commit_ptr_i, pop_rback_ptr_i} = '0;
        alloc_op_i = rtab_types_pkg::LOAD;
        {m_valid, m_head, outst, walk, out_ptr, walk_line} = '0;
        {seq_cnt, count, cyc} = '0;
        for (int i = 0; i < N; i++) begin
            {m_line[i], m_op[i], m_tag[i], m_deps[i], m_seq[i]} = '0;
        end
        rst_ni = 1'b0;
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;
        // Fill the table without popping
        for (int i = 0; i < N; i++) begin
            drive_cycle(2, 1'b0, 1'b0);
            check_and_update();
        end
        drive_cycle(0, 1'b0, 1'b0);
        check_and_update();
        check_eq(32'(full_o), 1, "full after filling the table");
        for (int i = 0; i < 3000; i++) begin
            drive_cycle(1, 1'b1, 1'b0);
            check_and_update();
        end
        guard = 0;
        while (count != 0 || outst) begin
            if (guard > 1000) begin
                $display("Timeout: table did not drain");
                $display("CHECKS FAILED");
                $fatal(1, "drain timeout");
            end
            guard++;
            drive_cycle(0, 1'b1, 1'b1);
            check_and_update();
        end
        drive_cycle(0, 1'b0, 1'b0);
        check_and_update();
        check_eq(32'(empty_o), 1, "empty after draining");
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== replay_table.f ====
verilog/rtab_cfg_pkg.sv
verilog/rtab_types_pkg.sv
verilog/rtab_pop_if.sv
verilog/rtab_entry_store.sv
verilog/rtab_dep_tracker.sv
verilog/rtab_rr_arbiter.sv
verilog/rtab_pop_fsm.sv
verilog/replay_table.sv
verification/replay_table_props.sv
verification/replay_table_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the replay table simulation with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
    --top-module replay_table_tb \
    -f replay_table.f \
    --Mdir build \
    -o replay_table_sim
./build/replay_table_sim
